// ==== common/bbc_pkg.sv ====
package bbc_pkg;

	// Widths with a meaning on the bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] mem_addr_t;
	typedef logic [14:0] disp_addr_t;
	typedef logic [13:0] crtc_ma_t;
	typedef logic [4:0]  crtc_ra_t;
	typedef logic [3:0]  romsel_t;
	typedef logic [3:0]  phase_t;

	// One CPU access as seen at the bus cycle boundary
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     wdata;
		logic      we;
	} cpu_req_t;

	// Shared RAM port
	typedef struct packed {
		mem_addr_t adr;
		byte_t     wdata;
	} mem_bus_t;

	// IC32 addressable latch, declared MSB first so sound_we_n is bit 0
	typedef struct packed {
		logic       shift_led_n;
		logic       caps_led_n;
		logic [1:0] disp_offs;
		logic       keyb_auto_n;
		logic       speech_rd_n;
		logic       speech_wr_n;
		logic       sound_we_n;
	} sys_flags_t;

	typedef enum logic [1:0] {S_RESET, S_VIDEO, S_CPU, S_WRITE} slot_state_t;

	// Phase numbers inside one 16-step bus cycle
	localparam phase_t PHASE_CPU_START = 4'd8;
	localparam phase_t PHASE_WRITE     = 4'd12;
	localparam phase_t PHASE_LAST      = 4'd15;

	// FE30..FE3F
	localparam logic [11:0] ROMSEL_PAGE = 12'hFE3;

endpackage

// ==== hdl/phase_timer.sv ====
module phase_timer (
	input  logic CLK32M_I,
	input  logic reset_i,
	output logic phi0_o,
	output logic cpu_start_o,
	output logic wr_strobe_o,
	output logic cpu_clken_o
);

	bbc_pkg::phase_t phase_q;
	bbc_pkg::phase_t phase_next;

	// Wraps from 15 back to 0 on its own
	assign phase_next = phase_q + 4'd1;

	// Decode from the next count so each output lines up with its phase
	always_ff @(posedge CLK32M_I)
	begin
		if (reset_i)
		begin
			phase_q     <= '0;
			phi0_o      <= 1'b0;
			cpu_start_o <= 1'b0;
			wr_strobe_o <= 1'b0;
			cpu_clken_o <= 1'b0;
		end
		else
		begin
			phase_q     <= phase_next;
			// CPU half is phases 8..15
			phi0_o      <= (phase_next >= bbc_pkg::PHASE_CPU_START);
			cpu_start_o <= (phase_next == bbc_pkg::PHASE_CPU_START);
			wr_strobe_o <= (phase_next == bbc_pkg::PHASE_WRITE);
			cpu_clken_o <= (phase_next == bbc_pkg::PHASE_LAST);
		end
	end

endmodule

// ==== hdl/slot_sequencer.sv ====
module slot_sequencer (
	input  logic                  CLK32M_I,
	input  logic                  reset_i,
	input  logic                  cpu_start_i,
	input  logic                  wr_strobe_i,
	input  logic                  cpu_clken_i,
	input  bbc_pkg::cpu_req_t     cpu_req_i,
	input  bbc_pkg::disp_addr_t   disp_addr_i,
	output bbc_pkg::mem_bus_t     mem_o,
	output logic                  mem_we_o
);

	bbc_pkg::slot_state_t state_q;
	bbc_pkg::slot_state_t state_next;
	bbc_pkg::cpu_req_t    req_q;

	// Slot transitions
	always_comb
	begin
		state_next = state_q;
		case (state_q)
			bbc_pkg::S_RESET:
			begin
				// Wait for the counter wrap so the first video half is complete
				if (cpu_clken_i)
					state_next = bbc_pkg::S_VIDEO;
			end
			bbc_pkg::S_VIDEO:
			begin
				if (cpu_start_i)
					state_next = bbc_pkg::S_CPU;
			end
			bbc_pkg::S_CPU:
			begin
				if (cpu_clken_i)
					state_next = bbc_pkg::S_VIDEO;
				else if (wr_strobe_i && req_q.we)
					state_next = bbc_pkg::S_WRITE;
			end
			bbc_pkg::S_WRITE:
			begin
				// Single clock strobe
				state_next = bbc_pkg::S_CPU;
			end
			default:
			begin
				state_next = bbc_pkg::S_RESET;
			end
		endcase
	end

	always_ff @(posedge CLK32M_I)
	begin
		if (reset_i)
			state_q <= bbc_pkg::S_RESET;
		else
			state_q <= state_next;
	end

	// CPU request captured at the start of the CPU half
	always_ff @(posedge CLK32M_I)
	begin
		if (state_q == bbc_pkg::S_VIDEO && cpu_start_i)
			req_q <= cpu_req_i;
	end

	// Address mux, display owns the bus until the CPU half begins
	always_comb
	begin
		if (state_q == bbc_pkg::S_CPU || state_q == bbc_pkg::S_WRITE)
			mem_o.adr = req_q.addr;
		else
			mem_o.adr = {1'b0, disp_addr_i};
		mem_o.wdata = req_q.wdata;
	end

	assign mem_we_o = (state_q == bbc_pkg::S_WRITE);

endmodule

// ==== hdl/display_addr.sv ====
module display_addr (
	input  logic                CLK32M_I,
	input  logic                reset_i,
	input  bbc_pkg::crtc_ma_t   crtc_ma_i,
	input  bbc_pkg::crtc_ra_t   crtc_ra_i,
	input  logic [1:0]          disp_offs_i,
	output bbc_pkg::disp_addr_t disp_addr_o
);

	logic [3:0]          mode_offs;
	logic [3:0]          nibble;
	bbc_pkg::disp_addr_t addr_next;

	// Wrap correction per screen mode group
	always_comb
	begin
		case (disp_offs_i)
			2'd0: mode_offs = 4'd8;   // mode 3, restart at 0x4000
			2'd1: mode_offs = 4'd12;  // mode 6, restart at 0x6000
			2'd2: mode_offs = 4'd6;   // modes 0-2, restart at 0x3000
			default: mode_offs = 4'd11;
		endcase
	end

	always_comb
	begin
		// Past the top of RAM when MA12 is set
		if (crtc_ma_i[12])
			nibble = crtc_ma_i[11:8] + mode_offs;
		else
			nibble = crtc_ma_i[11:8];

		// Teletext fetches from the 1K window at 0x3C00 or 0x7C00
		if (crtc_ma_i[13])
			addr_next = {nibble[3], 4'b1111, crtc_ma_i[9:0]};
		else
			addr_next = {nibble, crtc_ma_i[7:0], crtc_ra_i[2:0]};
	end

	always_ff @(posedge CLK32M_I)
	begin
		if (reset_i)
			disp_addr_o <= '0;
		else
			disp_addr_o <= addr_next;
	end

endmodule

// ==== hdl/sys_latch.sv ====
module sys_latch (
	input  logic                CLK32M_I,
	input  logic                reset_i,
	input  logic                cpu_clken_i,
	input  bbc_pkg::cpu_req_t   cpu_req_i,
	input  bbc_pkg::byte_t      via_pb_i,
	output bbc_pkg::romsel_t    romsel_o,
	output bbc_pkg::sys_flags_t flags_o
);

	bbc_pkg::byte_t latch_q;
	logic           romsel_wr;

	// Paged ROM register write at the end of the CPU cycle
	assign romsel_wr = cpu_clken_i && cpu_req_i.we
		&& (cpu_req_i.addr[15:4] == bbc_pkg::ROMSEL_PAGE);

	always_ff @(posedge CLK32M_I)
	begin
		if (reset_i)
		begin
			romsel_o <= '0;
			latch_q  <= '0;
		end
		else
		begin
			if (romsel_wr)
				romsel_o <= cpu_req_i.wdata[3:0];
			// PB2..0 select the bit, PB3 is the value
			latch_q[via_pb_i[2:0]] <= via_pb_i[3];
		end
	end

	assign flags_o = bbc_pkg::sys_flags_t'(latch_q);

endmodule

// ==== hdl/bbc_mem_sys.sv ====
module bbc_mem_sys (
	input  logic                CLK32M_I,
	input  logic                reset_i,
	input  bbc_pkg::cpu_req_t   cpu_req_i,
	input  bbc_pkg::crtc_ma_t   crtc_ma_i,
	input  bbc_pkg::crtc_ra_t   crtc_ra_i,
	input  bbc_pkg::byte_t      via_pb_i,
	output bbc_pkg::mem_bus_t   mem_o,
	output logic                mem_we_o,
	output logic                mem_sync_o,
	output logic                phi0_o,
	output bbc_pkg::romsel_t    romsel_o,
	output bbc_pkg::sys_flags_t flags_o
);

	logic                cpu_start;
	logic                wr_strobe;
	logic                cpu_clken;
	bbc_pkg::disp_addr_t disp_addr;

	// SDRAM controller syncs to the CPU clock enable
	assign mem_sync_o = cpu_clken;

	phase_timer u_phase_timer (
		.CLK32M_I    (CLK32M_I),
		.reset_i     (reset_i),
		.phi0_o      (phi0_o),
		.cpu_start_o (cpu_start),
		.wr_strobe_o (wr_strobe),
		.cpu_clken_o (cpu_clken)
	);

	slot_sequencer u_slot_sequencer (
		.CLK32M_I    (CLK32M_I),
		.reset_i     (reset_i),
		.cpu_start_i (cpu_start),
		.wr_strobe_i (wr_strobe),
		.cpu_clken_i (cpu_clken),
		.cpu_req_i   (cpu_req_i),
		.disp_addr_i (disp_addr),
		.mem_o       (mem_o),
		.mem_we_o    (mem_we_o)
	);

	display_addr u_display_addr (
		.CLK32M_I    (CLK32M_I),
		.reset_i     (reset_i),
		.crtc_ma_i   (crtc_ma_i),
		.crtc_ra_i   (crtc_ra_i),
		.disp_offs_i (flags_o.disp_offs),
		.disp_addr_o (disp_addr)
	);

	sys_latch u_sys_latch (
		.CLK32M_I    (CLK32M_I),
		.reset_i     (reset_i),
		.cpu_clken_i (cpu_clken),
		.cpu_req_i   (cpu_req_i),
		.via_pb_i    (via_pb_i),
		.romsel_o    (romsel_o),
		.flags_o     (flags_o)
	);

endmodule

// ==== dv/clk_gen.sv ====
module clk_gen (
	output logic clk_o,
	output logic reset_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial
	begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// Three reset edges, released on a falling edge
	initial
	begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// ==== dv/bbc_mem_sys_props.sv ====
module bbc_mem_sys_props (
	input  logic                 CLK32M_I,
	input  logic                 reset_i,
	input  logic                 wr_strobe_i,
	input  bbc_pkg::slot_state_t state_i,
	input  bbc_pkg::cpu_req_t    req_i,
	input  logic                 mem_we_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// Write pulse follows the write strobe seen in the CPU slot
	a_we_in_write: assert property (@(posedge CLK32M_I) disable iff (reset_i)
		mem_we_i |-> $past(wr_strobe_i && state_i == bbc_pkg::S_CPU))
		else $error("mem_we_o high without a write strobe in the CPU slot");

	a_write_one_clock: assert property (@(posedge CLK32M_I) disable iff (reset_i)
		(state_i == bbc_pkg::S_WRITE) |=> (state_i != bbc_pkg::S_WRITE))
		else $error("write slot held for more than one clock");

	// Latched request must be a write
	a_write_needs_we: assert property (@(posedge CLK32M_I) disable iff (reset_i)
		(state_i == bbc_pkg::S_WRITE) |-> req_i.we)
		else $error("write slot entered without a latched write request");

endmodule

bind slot_sequencer bbc_mem_sys_props u_props (
	.CLK32M_I    (CLK32M_I),
	.reset_i     (reset_i),
	.wr_strobe_i (wr_strobe_i),
	.state_i     (state_q),
	.req_i       (req_q),
	.mem_we_i    (mem_we_o)
);

// ==== dv/tb_bbc_mem_sys.sv ====
module tb_bbc_mem_sys;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BUS_CYCLES = 48;
	localparam int TIMEOUT_NS = BUS_CYCLES * 16 * 20 + 2000;

	logic                clk;
	logic                rst;
	bbc_pkg::cpu_req_t   cpu_req;
	bbc_pkg::crtc_ma_t   crtc_ma;
	bbc_pkg::crtc_ra_t   crtc_ra;
	bbc_pkg::byte_t      via_pb;
	bbc_pkg::mem_bus_t   mem;
	logic                mem_we;
	logic                mem_sync;
	logic                phi0;
	bbc_pkg::romsel_t    romsel;
	bbc_pkg::sys_flags_t flags;

	// Model state, phase counted from reset release
	int                  phase_n;
	bbc_pkg::byte_t      latch_exp;
	bbc_pkg::romsel_t    romsel_exp;
	logic [31:0]         lfsr_q;
	int                  fail_count = 0;
	int                  checks_done = 0;
	string               chk_name[$];
	logic [31:0]         chk_exp[$];
	logic [31:0]         chk_act[$];
	time                 chk_time[$];

	clk_gen u_clk_gen (
		.clk_o   (clk),
		.reset_o (rst)
	);

	bbc_mem_sys u_dut (
		.CLK32M_I   (clk),
		.reset_i    (rst),
		.cpu_req_i  (cpu_req),
		.crtc_ma_i  (crtc_ma),
		.crtc_ra_i  (crtc_ra),
		.via_pb_i   (via_pb),
		.mem_o      (mem),
		.mem_we_o   (mem_we),
		.mem_sync_o (mem_sync),
		.phi0_o     (phi0),
		.romsel_o   (romsel),
		.flags_o    (flags)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// Screen address from CRTC MA/RA and the mode offset
	function automatic bbc_pkg::disp_addr_t disp_addr_rule(input bbc_pkg::crtc_ma_t ma,
		input bbc_pkg::crtc_ra_t ra, input logic [1:0] offs);
		logic [3:0] off;
		logic [3:0] nib;
		case (offs)
			2'd0: off = 4'd8;
			2'd1: off = 4'd12;
			2'd2: off = 4'd6;
			default: off = 4'd11;
		endcase
		nib = ma[11:8];
		if (ma[12])
			nib = nib + off;
		if (ma[13])
			return {nib[3], 4'b1111, ma[9:0]};
		return {nib, ma[7:0], ra[2:0]};
	endfunction

	function automatic bbc_pkg::byte_t latch_update(input bbc_pkg::byte_t cur,
		input bbc_pkg::byte_t pb);
		bbc_pkg::byte_t r;
		r = cur;
		r[pb[2:0]] = pb[3];
		return r;
	endfunction

	function automatic bbc_pkg::romsel_t romsel_update(input bbc_pkg::romsel_t cur,
		input bbc_pkg::cpu_req_t req);
		if (req.we && req.addr[15:4] == bbc_pkg::ROMSEL_PAGE)
			return req.wdata[3:0];
		return cur;
	endfunction

	task automatic queue_check(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		chk_name.push_back(name);
		chk_exp.push_back(exp_v);
		chk_act.push_back(act_v);
		chk_time.push_back($time);
	endtask

	// One clock, model follows the rising edge, outputs sampled at the falling edge
	task automatic step_clock();
		latch_exp = latch_update(latch_exp, via_pb);
		if (phase_n == 15)
			romsel_exp = romsel_update(romsel_exp, cpu_req);
		@(negedge clk);
		phase_n = (phase_n + 1) % 16;
		queue_check("phi0_o", 32'(phase_n >= 8), 32'(phi0));
		queue_check("mem_sync_o", 32'(phase_n == 15), 32'(mem_sync));
		queue_check("romsel_o", 32'(romsel_exp), 32'(romsel));
		queue_check("flags_o", 32'(latch_exp), 32'(flags));
	endtask

	task automatic run_to_phase(input int p);
		do
			step_clock();
		while (phase_n != p);
	endtask

	// Latch bits 4 and 5 hold disp_offs
	task automatic set_disp_mode(input logic [1:0] offs);
		via_pb = {4'b0, offs[0], 3'd4};
		step_clock();
		via_pb = {4'b0, offs[1], 3'd5};
		step_clock();
	endtask

	initial
	begin
		logic [31:0]       v;
		bbc_pkg::cpu_req_t req;
		bbc_pkg::crtc_ma_t ma;
		bbc_pkg::crtc_ra_t ra;
		int                pulses;
		int                highs;
		int                syncs;

		cpu_req = '0;
		crtc_ma = '0;
		crtc_ra = '0;
		via_pb = '0;
		phase_n = 0;
		latch_exp = '0;
		romsel_exp = '0;
		lfsr_q = 32'h2ba1d1e3;
		@(negedge rst);

		step_clock();
		queue_check("mem_we_o", 32'd0, 32'(mem_we));
		queue_check("phi0_o", 32'd0, 32'(phi0));
		queue_check("mem_sync_o", 32'd0, 32'(mem_sync));
		queue_check("romsel_o", 32'd0, 32'(romsel));
		queue_check("flags_o", 32'd0, 32'(flags));

		// Two bus cycles of phi0 and sync framing
		highs = 0;
		syncs = 0;
		repeat (32)
		begin
			step_clock();
			if (phi0)
				highs++;
			if (mem_sync)
				syncs++;
		end
		queue_check("phi0_o high clocks", 32'd16, 32'(highs));
		queue_check("mem_sync_o pulses", 32'd2, 32'(syncs));

		// Display half, all four offsets, plain, wrapped and teletext
		for (int offs = 0; offs < 4; offs++)
		begin
			for (int kind = 0; kind < 3; kind++)
			begin
				run_to_phase(0);
				set_disp_mode(2'(offs));
				draw_bits(19, v);
				ma = v[13:0];
				ra = v[18:14];
				ma[13] = (kind == 2);
				if (kind != 2)
					ma[12] = (kind == 1);
				crtc_ma = ma;
				crtc_ra = ra;
				run_to_phase(8);
				queue_check("mem_o.adr", 32'({1'b0, disp_addr_rule(ma, ra, 2'(offs))}),
					32'(mem.adr));
			end
		end

		// CPU half, writes and reads kept out of the ROM select page
		run_to_phase(0);
		for (int i = 0; i < 10; i++)
		begin
			draw_bits(25, v);
			req.addr = v[24:9];
			req.wdata = v[8:1];
			req.we = (i % 2 == 0);
			if (req.addr[15:4] == bbc_pkg::ROMSEL_PAGE)
				req.addr[4] = 1'b0;
			cpu_req = req;
			pulses = 0;
			repeat (16)
			begin
				step_clock();
				if (phase_n >= 9)
					queue_check("mem_o.adr", 32'(req.addr), 32'(mem.adr));
				if (mem_we)
				begin
					pulses++;
					queue_check("phi0_o", 32'd1, 32'(phi0));
					queue_check("mem_o.wdata", 32'(req.wdata), 32'(mem.wdata));
				end
				// Inputs change once the request is latched
				if (phase_n == 9)
					cpu_req = ~req;
			end
			queue_check("mem_we_o pulses", 32'(req.we), 32'(pulses));
		end

		// ROM select, hits, a miss and a read
		for (int i = 0; i < 8; i++)
		begin
			draw_bits(12, v);
			req.addr = {bbc_pkg::ROMSEL_PAGE, v[3:0]};
			req.wdata = v[11:4];
			req.we = (i % 4 != 2);
			if (i % 4 == 1)
				req.addr[15:8] = 8'hFD;
			cpu_req = req;
			repeat (16) step_clock();
			queue_check("romsel_o", 32'(romsel_exp), 32'(romsel));
		end
		cpu_req = '0;

		// Addressable latch
		for (int i = 0; i < 24; i++)
		begin
			draw_bits(8, v);
			via_pb = v[7:0];
			step_clock();
			step_clock();
			queue_check("flags_o", 32'(latch_exp), 32'(flags));
		end

		while (chk_name.size() != 0)
			@(posedge clk);
		@(posedge clk);
		if (fail_count == 0 && checks_done > 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("Run ended with %0d failed checks out of %0d", fail_count, checks_done);
			$display("TB FAILED");
			$fatal(1, "Run ended in failure");
		end
	end

	// Checker drains on rising edges, samples were taken at falling edges
	initial
	begin
		string       name;
		logic [31:0] exp_v;
		logic [31:0] act_v;
		time         t_v;
		forever
		begin
			@(posedge clk);
			while (chk_name.size() != 0)
			begin
				name = chk_name.pop_front();
				exp_v = chk_exp.pop_front();
				act_v = chk_act.pop_front();
				t_v = chk_time.pop_front();
				checks_done++;
				assert (act_v === exp_v)
				else
				begin
					fail_count++;
					$display("[FAIL] t=%0t %s expected=%0h actual=%0h", t_v, name, exp_v, act_v);
					$display("TB FAILED");
					$fatal(1, "Mismatch on %s", name);
				end
			end
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests finished");
		$display("TB FAILED");
		$fatal(1, "Timeout");
	end

endmodule

// ==== vlog.f ====
common/bbc_pkg.sv
hdl/phase_timer.sv
hdl/slot_sequencer.sv
hdl/display_addr.sv
hdl/sys_latch.sv
hdl/bbc_mem_sys.sv
dv/clk_gen.sv
dv/bbc_mem_sys_props.sv
dv/tb_bbc_mem_sys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_bbc_mem_sys
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
